// File: logic/fmPkg.sv
`default_nettype none

package fmPkg;

  // Default widths of the AC field and the AC block number
  localparam int AcWidth = 4;
  localparam int BlockWidth = 3;

  // Fast-memory address source, in microcode FMADR order
  typedef enum logic [2:0] {
    ac          = 3'd0,
    acPlus1     = 3'd1,
    xr          = 3'd2,
    vma         = 3'd3,
    acPlus2     = 3'd4,
    acPlus3     = 3'd5,
    acPlusMagic = 3'd6,
    magic       = 3'd7
  } fmSrcT;

  // Block selects one of the AC sets, address the AC within it
  typedef struct packed {
    logic [BlockWidth-1:0] block;
    logic [AcWidth-1:0]    address;
  } fmAddrT;

endpackage

`default_nettype wire

// File: logic/aprPkg.sv
`default_nettype none

package aprPkg;

  localparam int NumFlags = 8;

  // One bit per status flag
  typedef logic [NumFlags-1:0] aprFlagT;

  // Flag positions in aprFlagT
  localparam int FlagSbusErr    = 0;
  localparam int FlagNxmErr     = 1;
  localparam int FlagIoPfErr    = 2;
  localparam int FlagMbParErr   = 3;
  localparam int FlagCDirParErr = 4;
  localparam int FlagSAdrParErr = 5;
  localparam int FlagPwrFail    = 6;
  localparam int FlagSweepDone  = 7;

  // Internal bus data word
  typedef logic [17:0] ebusWordT;

  // Condition output, applied to every flag whose mask bit is set
  typedef struct packed {
    logic    selSet;
    logic    selClr;
    logic    selEn;
    logic    selDis;
    aprFlagT mask;
  } condoCmdT;

  // Data output, AC block numbers and address compare enables
  typedef struct packed {
    logic [fmPkg::BlockWidth-1:0] curBlock;
    logic [fmPkg::BlockWidth-1:0] prevBlock;
    logic                         fetchComp;
    logic                         readComp;
    logic                         writeComp;
    logic                         userComp;
  } datoCmdT;

  typedef logic [2:0] diagFuncT;

endpackage

`default_nettype wire

// File: logic/aprFlagBank.sv
`timescale 1ns/1ps
`default_nettype none

module aprFlagBank #(
  parameter int NumFlags = aprPkg::NumFlags
) (
  input  logic             clk,
  input  logic             arstN,
  input  logic             condoStrobe,
  input  aprPkg::condoCmdT condoCmd,
  input  aprPkg::aprFlagT  condIn,
  output aprPkg::aprFlagT  flags,
  output aprPkg::aprFlagT  enables,
  output logic             interrupt,
  output logic             anyEboxErr
);

  logic [NumFlags-1:0] selMask;
  logic [NumFlags-1:0] setMask;
  logic [NumFlags-1:0] clrMask;
  logic [NumFlags-1:0] enMask;
  logic [NumFlags-1:0] disMask;
  logic [NumFlags-1:0] flagsNext;
  logic [NumFlags-1:0] enablesNext;
  logic                errAny;

  // Mask only counts while the bus strobe is up
  assign selMask = condoStrobe ? condoCmd.mask : '0;
  assign setMask = selMask & {NumFlags{condoCmd.selSet}};
  assign clrMask = selMask & {NumFlags{condoCmd.selClr}};
  assign enMask  = selMask & {NumFlags{condoCmd.selEn}};
  assign disMask = selMask & {NumFlags{condoCmd.selDis}};

  // A live condition level beats a clear from the bus
  assign flagsNext = condIn | setMask | (flags & ~clrMask);

  // Enable beats disable on the same mask bit
  assign enablesNext = enMask | (enables & ~disMask);

  // Memory side errors that feed the EBOX error flop
  assign errAny = flags[aprPkg::FlagNxmErr] |
                  flags[aprPkg::FlagMbParErr] |
                  flags[aprPkg::FlagSAdrParErr];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags   <= '0;
      enables <= '0;
    end else begin
      flags   <= flagsNext;
      enables <= enablesNext;
    end
  end

  // One cycle behind the flags
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      anyEboxErr <= 1'b0;
    end else begin
      anyEboxErr <= errAny;
    end
  end

  assign interrupt = |(flags & enables);

endmodule

`default_nettype wire

// File: logic/aprCtlRegs.sv
`timescale 1ns/1ps
`default_nettype none

module aprCtlRegs #(
  parameter int BlockWidth = fmPkg::BlockWidth
) (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  datoStrobe,
  input  aprPkg::datoCmdT       datoCmd,
  input  logic                  loadVmaContext,
  input  logic                  vmaPrevEn,
  input  logic                  xrPrevious,
  output logic [BlockWidth-1:0] curBlock,
  output logic [BlockWidth-1:0] prevBlock,
  output logic [BlockWidth-1:0] vmaBlock,
  output logic [BlockWidth-1:0] xrBlock,
  output logic [3:0]            compareBits
);

  logic [BlockWidth-1:0] vmaBlockNext;

  // AC blocks and compare bits written by a data output
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      curBlock    <= '0;
      prevBlock   <= '0;
      compareBits <= '0;
    end else if (datoStrobe) begin
      curBlock    <= datoCmd.curBlock;
      prevBlock   <= datoCmd.prevBlock;
      // Fetch in the top bit, user in the bottom
      compareBits <= {datoCmd.fetchComp, datoCmd.readComp,
                      datoCmd.writeComp, datoCmd.userComp};
    end
  end

  // VMA context takes the block in force before this edge
  assign vmaBlockNext = vmaPrevEn ? prevBlock : curBlock;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      vmaBlock <= '0;
    end else if (loadVmaContext) begin
      vmaBlock <= vmaBlockNext;
    end
  end

  // Index register lives in the previous context when asked
  assign xrBlock = xrPrevious ? prevBlock : curBlock;

endmodule

`default_nettype wire

// File: logic/fmAddrSel.sv
`timescale 1ns/1ps
`default_nettype none

module fmAddrSel #(
  parameter int AcWidth    = fmPkg::AcWidth,
  parameter int BlockWidth = fmPkg::BlockWidth
) (
  input  fmPkg::fmSrcT                   fmSrc,
  input  logic [AcWidth-1:0]             ac,
  input  logic [AcWidth-1:0]             xr,
  input  logic [AcWidth-1:0]             vmaLow,
  input  logic [BlockWidth+AcWidth-1:0]  magic,
  input  logic [BlockWidth-1:0]          curBlock,
  input  logic [BlockWidth-1:0]          vmaBlock,
  input  logic [BlockWidth-1:0]          xrBlock,
  output fmPkg::fmAddrT                  fmAddr
);

  logic [AcWidth-1:0]    acInc1;
  logic [AcWidth-1:0]    acInc2;
  logic [AcWidth-1:0]    acInc3;
  logic [AcWidth-1:0]    acSum;
  logic [AcWidth-1:0]    addr;
  logic [BlockWidth-1:0] blk;

  // All sums wrap within the AC field
  assign acInc1 = ac + AcWidth'(1);
  assign acInc2 = ac + AcWidth'(2);
  assign acInc3 = ac + AcWidth'(3);
  assign acSum  = ac + magic[AcWidth-1:0];

  always_comb begin
    // AC-relative sources stay in the current block
    blk  = curBlock;
    addr = ac;
    case (fmSrc)
      fmPkg::ac:          addr = ac;
      fmPkg::acPlus1:     addr = acInc1;
      fmPkg::acPlus2:     addr = acInc2;
      fmPkg::acPlus3:     addr = acInc3;
      fmPkg::acPlusMagic: addr = acSum;
      fmPkg::xr: begin
        blk  = xrBlock;
        addr = xr;
      end
      fmPkg::vma: begin
        blk  = vmaBlock;
        addr = vmaLow;
      end
      fmPkg::magic: begin
        // Microcode names both block and AC directly
        blk  = magic[BlockWidth+AcWidth-1:AcWidth];
        addr = magic[AcWidth-1:0];
      end
      default: addr = ac;
    endcase
  end

  assign fmAddr = '{block: blk, address: addr};

endmodule

`default_nettype wire

// File: logic/aprDiagRead.sv
`timescale 1ns/1ps
`default_nettype none

module aprDiagRead (
  input  logic                         diagStrobe,
  input  aprPkg::diagFuncT             diagFunc,
  input  aprPkg::aprFlagT              flags,
  input  aprPkg::aprFlagT              enables,
  input  logic [fmPkg::BlockWidth-1:0] curBlock,
  input  logic [fmPkg::BlockWidth-1:0] prevBlock,
  input  logic [3:0]                   compareBits,
  input  fmPkg::fmAddrT                fmAddr,
  input  logic                         interrupt,
  input  logic                         anyEboxErr,
  output aprPkg::ebusWordT             diagData
);

  aprPkg::ebusWordT word;

  // Each function is right-justified in the bus word
  always_comb begin
    word = '0;
    case (diagFunc)
      3'd0: word = aprPkg::ebusWordT'(flags);
      // Current block above previous block
      3'd1: word = aprPkg::ebusWordT'({curBlock, prevBlock});
      3'd2: word = aprPkg::ebusWordT'(enables);
      3'd3: word = aprPkg::ebusWordT'(compareBits);
      3'd4: word = aprPkg::ebusWordT'(fmAddr);
      3'd5: word = aprPkg::ebusWordT'({interrupt, anyEboxErr});
      default: word = '0;
    endcase
  end

  // Bus is only driven while the read strobe is up
  assign diagData = diagStrobe ? word : '0;

endmodule

`default_nettype wire

// File: logic/aprTop.sv
`timescale 1ns/1ps
`default_nettype none

module aprTop #(
  parameter int NumFlags   = aprPkg::NumFlags,
  parameter int AcWidth    = fmPkg::AcWidth,
  parameter int BlockWidth = fmPkg::BlockWidth
) (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          condoStrobe,
  input  aprPkg::condoCmdT              condoCmd,
  input  logic                          datoStrobe,
  input  aprPkg::datoCmdT               datoCmd,
  input  aprPkg::aprFlagT               condIn,
  input  logic [AcWidth-1:0]            ac,
  input  logic [AcWidth-1:0]            xr,
  input  logic [AcWidth-1:0]            vmaLow,
  input  logic                          loadVmaContext,
  input  logic                          vmaPrevEn,
  input  logic                          xrPrevious,
  input  fmPkg::fmSrcT                  fmSrc,
  input  logic [BlockWidth+AcWidth-1:0] magic,
  input  logic                          diagStrobe,
  input  aprPkg::diagFuncT              diagFunc,
  output logic                          interrupt,
  output logic                          anyEboxErr,
  output fmPkg::fmAddrT                 fmAddr,
  output aprPkg::ebusWordT              diagData
);

  aprPkg::aprFlagT       flags;
  aprPkg::aprFlagT       enables;
  logic [BlockWidth-1:0] curBlock;
  logic [BlockWidth-1:0] prevBlock;
  logic [BlockWidth-1:0] vmaBlock;
  logic [BlockWidth-1:0] xrBlock;
  logic [3:0]            compareBits;

  aprFlagBank #(.NumFlags(NumFlags)) i_flagBank (
    .clk, .arstN, .condoStrobe, .condoCmd, .condIn,
    .flags, .enables, .interrupt, .anyEboxErr
  );

  aprCtlRegs #(.BlockWidth(BlockWidth)) i_ctlRegs (
    .clk, .arstN, .datoStrobe, .datoCmd, .loadVmaContext, .vmaPrevEn,
    .xrPrevious, .curBlock, .prevBlock, .vmaBlock, .xrBlock, .compareBits
  );

  fmAddrSel #(.AcWidth(AcWidth), .BlockWidth(BlockWidth)) i_fmAddrSel (
    .fmSrc, .ac, .xr, .vmaLow, .magic, .curBlock, .vmaBlock, .xrBlock, .fmAddr
  );

  // Read mux sees the same fast-memory address as the output port
  aprDiagRead i_diagRead (
    .diagStrobe, .diagFunc, .flags, .enables, .curBlock, .prevBlock,
    .compareBits, .fmAddr, .interrupt, .anyEboxErr, .diagData
  );

endmodule

`default_nettype wire

// File: test/aprClkGen.sv
`timescale 1ns/1ps
`default_nettype none

module aprClkGen (
  output logic clk
);

  // 8 ns period, starts low
  initial clk = 1'b0;
  always #4 clk = ~clk;

endmodule

`default_nettype wire

// File: test/aprFlag_properties.sv
`timescale 1ns/1ps
`default_nettype none

module aprFlagProperties (
  input logic             clk,
  input logic             arstN,
  input logic             condoStrobe,
  input aprPkg::condoCmdT condoCmd,
  input aprPkg::aprFlagT  condIn,
  input aprPkg::aprFlagT  flags,
  input aprPkg::aprFlagT  enables,
  input logic             interrupt
);

  // Flags come out of reset cleared
  resetClears: assert property (@(posedge clk) $rose(arstN) |-> flags == '0)
    else $error("flags not zero when reset was released");

  // A new interrupt needs a condition, a bus set or a bus enable one edge earlier
  intHasSource: assert property (@(posedge clk) disable iff (!arstN)
    $rose(interrupt) |-> $past(condIn != '0 ||
      (condoStrobe && (condoCmd.selSet || condoCmd.selEn))))
    else $error("interrupt rose with no condition, set or enable behind it");

  // A condition level always lands in its flag
  condSetsFlag: assert property (@(posedge clk) disable iff (!arstN)
    condIn != '0 |=> (flags & $past(condIn)) == $past(condIn))
    else $error("condition level did not set its flag");

endmodule

bind aprFlagBank aprFlagProperties i_flagProps (
  .clk(clk), .arstN(arstN), .condoStrobe(condoStrobe), .condoCmd(condoCmd),
  .condIn(condIn), .flags(flags), .enables(enables), .interrupt(interrupt)
);

`default_nettype wire

// File: test/aprTb.sv
`timescale 1ns/1ps
`default_nettype none

module aprTb;

  localparam int AcW = fmPkg::AcWidth;
  localparam int BlkW = fmPkg::BlockWidth;
  localparam int MagicW = AcW + BlkW;
  localparam int CycleLimit = 2000;
  // Condition output selects, in condoCmdT order
  localparam logic [3:0] SelClr = 4'b0100;
  localparam logic [3:0] SelEn = 4'b0010;
  localparam logic [3:0] SelDis = 4'b0001;

  typedef struct packed {
    logic             interrupt;
    logic             anyEboxErr;
    fmPkg::fmAddrT    fmAddr;
    aprPkg::ebusWordT diagData;
  } outT;

  logic clk;
  logic arstN;
  logic condoStrobe;
  logic datoStrobe;
  logic loadVmaContext;
  logic vmaPrevEn;
  logic xrPrevious;
  logic diagStrobe;
  aprPkg::condoCmdT condoCmd;
  aprPkg::datoCmdT datoCmd;
  aprPkg::aprFlagT condIn;
  logic [AcW-1:0] ac;
  logic [AcW-1:0] xr;
  logic [AcW-1:0] vmaLow;
  logic [MagicW-1:0] magic;
  fmPkg::fmSrcT fmSrc;
  aprPkg::diagFuncT diagFunc;
  logic interrupt;
  logic anyEboxErr;
  fmPkg::fmAddrT fmAddr;
  aprPkg::ebusWordT diagData;
  outT dutOut;

  // Model of the registered DUT state
  aprPkg::aprFlagT mFlags = '0;
  aprPkg::aprFlagT mEnables = '0;
  logic mErr = 1'b0;
  logic [BlkW-1:0] mCur = '0;
  logic [BlkW-1:0] mPrev = '0;
  logic [BlkW-1:0] mVma = '0;
  logic [3:0] mCmp = '0;
  int checkErrors = 0;
  int timeoutErrors = 0;

  aprClkGen i_clkGen (.clk(clk));

  aprTop #(.NumFlags(aprPkg::NumFlags), .AcWidth(AcW), .BlockWidth(BlkW)) i_dut (.*);

  assign dutOut = {interrupt, anyEboxErr, fmAddr, diagData};

  function automatic outT expectOut();
    outT r;
    logic [AcW-1:0] off;
    logic [AcW-1:0] addr;
    logic [BlkW-1:0] blk;
    aprPkg::ebusWordT word;
    r.interrupt = |(mFlags & mEnables);
    r.anyEboxErr = mErr;
    off = '0;
    if (fmSrc == fmPkg::acPlus1) off = AcW'(1);
    if (fmSrc == fmPkg::acPlus2) off = AcW'(2);
    if (fmSrc == fmPkg::acPlus3) off = AcW'(3);
    if (fmSrc == fmPkg::acPlusMagic) off = magic[AcW-1:0];
    blk = mCur;
    addr = ac + off;
    if (fmSrc == fmPkg::xr) begin
      blk = xrPrevious ? mPrev : mCur;
      addr = xr;
    end else if (fmSrc == fmPkg::vma) begin
      blk = mVma;
      addr = vmaLow;
    end else if (fmSrc == fmPkg::magic) begin
      {blk, addr} = magic;
    end
    r.fmAddr.block = blk;
    r.fmAddr.address = addr;
    word = '0;
    case (diagFunc)
      3'd0: word[aprPkg::NumFlags-1:0] = mFlags;
      3'd1: word[2*BlkW-1:0] = {mCur, mPrev};
      3'd2: word[aprPkg::NumFlags-1:0] = mEnables;
      3'd3: word[3:0] = mCmp;
      3'd4: word[MagicW-1:0] = {blk, addr};
      3'd5: word[1:0] = {r.interrupt, r.anyEboxErr};
      default: word = '0;
    endcase
    r.diagData = diagStrobe ? word : '0;
    return r;
  endfunction

  task automatic compareOut(input outT got, input outT exp, input string what);
    if (got !== exp) begin
      checkErrors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic stepCycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic condoWrite(input logic [3:0] sel, input aprPkg::aprFlagT mask);
    condoCmd = {sel, mask};
    condoStrobe = 1'b1;
    stepCycles(1);
    condoStrobe = 1'b0;
  endtask

  task automatic waitInterrupt(input logic level);
    int n;
    n = 0;
    while (interrupt !== level && n < 4) begin
      stepCycles(1);
      n++;
    end
    if (interrupt !== level) begin
      timeoutErrors++;
      $display("Timed out at %0t waiting for interrupt to go %0b", $time, level);
    end
  endtask

  // Old flags and blocks feed the lagging registers
  always @(posedge clk) begin : modelUpdate
    aprPkg::aprFlagT sel;
    if (!arstN) begin
      {mFlags, mEnables, mErr, mCur, mPrev, mVma, mCmp} = '0;
    end else begin
      sel = condoStrobe ? condoCmd.mask : '0;
      mErr = mFlags[aprPkg::FlagNxmErr] | mFlags[aprPkg::FlagMbParErr] |
             mFlags[aprPkg::FlagSAdrParErr];
      if (loadVmaContext) mVma = vmaPrevEn ? mPrev : mCur;
      if (datoStrobe) {mCur, mPrev, mCmp} = datoCmd;
      for (int i = 0; i < aprPkg::NumFlags; i++) begin
        if (sel[i] && condoCmd.selClr) mFlags[i] = 1'b0;
        if ((sel[i] && condoCmd.selSet) || condIn[i]) mFlags[i] = 1'b1;
        if (sel[i] && condoCmd.selDis) mEnables[i] = 1'b0;
        if (sel[i] && condoCmd.selEn) mEnables[i] = 1'b1;
      end
    end
  end

  always @(negedge clk) begin
    compareOut(dutOut, expectOut(), $sformatf("fmSrc=%0d diagFunc=%0d", fmSrc, diagFunc));
  end

  initial begin : watchdog
    for (int c = 0; c < CycleLimit; c++) @(posedge clk);
    $display("Simulation did not finish within %0d cycles", CycleLimit);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : stimulus
    aprPkg::aprFlagT pwrMask;
    void'($urandom(32'ha010_daaa));
    arstN = 1'b0;
    {condoStrobe, datoStrobe, loadVmaContext, vmaPrevEn, xrPrevious, diagStrobe} = '0;
    {condoCmd, datoCmd, condIn, ac, xr, vmaLow, magic, diagFunc} = '0;
    fmSrc = fmPkg::ac;
    pwrMask = '0;
    pwrMask[aprPkg::FlagPwrFail] = 1'b1;
    stepCycles(2);
    arstN = 1'b1;
    // Every diagnostic word reads zero after reset
    diagStrobe = 1'b1;
    for (int f = 0; f < 8; f++) begin
      diagFunc = f[2:0];
      stepCycles(1);
    end
    // Power fail flag, then enable, disable and clear
    condIn = pwrMask;
    stepCycles(1);
    condIn = '0;
    stepCycles(2);
    condoWrite(SelEn, pwrMask);
    waitInterrupt(1'b1);
    condoWrite(SelDis, pwrMask);
    waitInterrupt(1'b0);
    condoWrite(SelEn, pwrMask);
    waitInterrupt(1'b1);
    condoWrite(SelClr, pwrMask);
    waitInterrupt(1'b0);
    // Clear against a live condition on an error flag
    condIn[aprPkg::FlagNxmErr] = 1'b1;
    condoWrite(SelClr, '1);
    condIn = '0;
    stepCycles(2);
    condoWrite(SelClr | SelDis, '1);
    stepCycles(2);
    // Block registers through the read mux and fmAddr
    datoCmd = '{curBlock: 3'd5, prevBlock: 3'd2, fetchComp: 1'b1, readComp: 1'b0,
                writeComp: 1'b1, userComp: 1'b1};
    datoStrobe = 1'b1;
    stepCycles(1);
    datoStrobe = 1'b0;
    for (int p = 0; p < 2; p++) begin
      loadVmaContext = 1'b1;
      vmaPrevEn = p[0];
      xrPrevious = p[0];
      stepCycles(1);
      loadVmaContext = 1'b0;
      fmSrc = fmPkg::vma;
      for (int f = 1; f < 5; f++) begin
        diagFunc = f[2:0];
        stepCycles(1);
      end
      fmSrc = fmPkg::xr;
      stepCycles(1);
    end
    // Random traffic on every input
    for (int k = 0; k < 600; k++) begin
      fmSrc = fmPkg::fmSrcT'(3'($urandom));
      {ac, xr, vmaLow, magic} = (3 * AcW + MagicW)'($urandom);
      {diagStrobe, xrPrevious, loadVmaContext, vmaPrevEn} = 4'($urandom);
      diagFunc = 3'($urandom);
      condIn = ($urandom_range(7) == 0) ? aprPkg::aprFlagT'($urandom) : '0;
      condoStrobe = ($urandom_range(3) == 0);
      condoCmd = {4'($urandom), aprPkg::aprFlagT'($urandom)};
      datoStrobe = ($urandom_range(7) == 0);
      datoCmd = {BlkW'($urandom), BlkW'($urandom), 4'($urandom)};
      stepCycles(1);
    end
    {condoStrobe, datoStrobe, loadVmaContext, diagStrobe} = '0;
    condIn = '0;
    stepCycles(2);
    $display("Errors: %0d check, %0d timeout", checkErrors, timeoutErrors);
    if (checkErrors == 0 && timeoutErrors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
logic/fmPkg.sv
logic/aprPkg.sv
logic/aprFlagBank.sv
logic/aprCtlRegs.sv
logic/fmAddrSel.sv
logic/aprDiagRead.sv
logic/aprTop.sv
test/aprClkGen.sv
test/aprFlag_properties.sv
test/aprTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the APR testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module aprTb -Mdir obj_dir -f flist.f; then
  echo "Verilator build failed"
  exit 1
fi

if ! simOut="$(./obj_dir/VaprTb)"; then
  echo "$simOut"
  echo "Simulation exited with an error status"
  exit 1
fi
echo "$simOut"

if grep -qxF "=== PASS ===" <<< "$simOut"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1
